// File: source/regReadPkg.sv
//########################################
// shared sizes and types of the register-read stage
// PHYS_REGS and CHECKPOINTS are powers of two, so the
// tag and checkpoint-index widths cover them exactly
// registers 0 .. ARCH_REGS-1 are the ones ready after reset
//########################################

package regReadPkg;

  localparam int PHYS_REGS   = 32;
  localparam int ARCH_REGS   = 8; // ready after reset or flush
  localparam int CHECKPOINTS = 4;

  // physical register tag
  typedef logic [$clog2(PHYS_REGS)-1:0] physTag_t;

  // register value
  typedef logic [31:0] regData_t;

  // one bit per outstanding branch checkpoint
  typedef logic [CHECKPOINTS-1:0] branchMask_t;

  // index of a checkpoint within a branch mask
  typedef logic [$clog2(CHECKPOINTS)-1:0] ckptId_t;

  // one ready bit per physical register
  typedef logic [PHYS_REGS-1:0] readyVec_t;

endpackage

// File: source/physRegFile.sv
//########################################
// physical register file with 2*LANES read ports
// and WB_PORTS write ports
// reads are combinational and return stored content only
// writes land at the clock edge, lowest port wins on a clash
// contents are cleared by reset
//########################################

`timescale 1ns/10ps

module physRegFile #(
  parameter int LANES    = 2,
  parameter int WB_PORTS = 2
) (
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic [WB_PORTS-1:0]                 wbValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0] wbTag_i,
  input  regReadPkg::regData_t [WB_PORTS-1:0] wbData_i,
  input  regReadPkg::physTag_t [2*LANES-1:0]  rdTag_i,
  output regReadPkg::regData_t [2*LANES-1:0]  rdData_o
);

  regReadPkg::regData_t regs [regReadPkg::PHYS_REGS];

  // walk the ports from the top down so port 0 is applied last
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < regReadPkg::PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int p = WB_PORTS - 1; p >= 0; p--) begin
        if (wbValid_i[p]) begin
          regs[wbTag_i[p]] <= wbData_i[p];
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < 2 * LANES; r++) begin
      rdData_o[r] = regs[rdTag_i[r]]; // no bypass here, see operandForward
    end
  end

endmodule

// File: source/operandForward.sv
//########################################
// writeback forwarding and output register per lane
// lowest matching writeback port wins over the register file
// rfData_i is ordered lane-major, src1 then src2
// a lane is squashed when its mask holds the mispredicted checkpoint
// only the valid bits are reset, payload may be unknown when invalid
//########################################

`timescale 1ns/10ps

module operandForward #(
  parameter int LANES    = 2,
  parameter int WB_PORTS = 2
) (
  input  logic                                   clk,
  input  logic                                   reset_i,
  input  logic [LANES-1:0]                       issueValid_i,
  input  regReadPkg::physTag_t [LANES-1:0]       src1Tag_i,
  input  regReadPkg::physTag_t [LANES-1:0]       src2Tag_i,
  input  regReadPkg::physTag_t [LANES-1:0]       destTag_i,
  input  regReadPkg::branchMask_t [LANES-1:0]    branchMask_i,
  input  logic [WB_PORTS-1:0]                    wbValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0]    wbTag_i,
  input  regReadPkg::regData_t [WB_PORTS-1:0]    wbData_i,
  input  regReadPkg::regData_t [2*LANES-1:0]     rfData_i,
  input  logic                                   mispredictValid_i,
  input  regReadPkg::ckptId_t                    mispredictCkpt_i,
  output logic [LANES-1:0]                       opValid_o,
  output regReadPkg::regData_t [LANES-1:0]       op1_o,
  output regReadPkg::regData_t [LANES-1:0]       op2_o,
  output regReadPkg::physTag_t [LANES-1:0]       opDest_o
);

  logic [LANES-1:0]                 validNext;
  regReadPkg::regData_t [LANES-1:0] op1Next;
  regReadPkg::regData_t [LANES-1:0] op2Next;

  logic [LANES-1:0]                 validQ;
  regReadPkg::regData_t [LANES-1:0] op1Q;
  regReadPkg::regData_t [LANES-1:0] op2Q;
  regReadPkg::physTag_t [LANES-1:0] destQ;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      op1Next[l] = rfData_i[2*l];   // default to the stored value
      op2Next[l] = rfData_i[2*l+1];
      // descending scan leaves the lowest matching port in place
      for (int p = WB_PORTS - 1; p >= 0; p--) begin
        if (wbValid_i[p] && (wbTag_i[p] == src1Tag_i[l])) begin
          op1Next[l] = wbData_i[p];
        end
        if (wbValid_i[p] && (wbTag_i[p] == src2Tag_i[l])) begin
          op2Next[l] = wbData_i[p];
        end
      end
      validNext[l] = issueValid_i[l] &&
                     !(mispredictValid_i && branchMask_i[l][mispredictCkpt_i]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      validQ <= '0;
    end else begin
      validQ <= validNext;
    end
  end

  always_ff @(posedge clk) begin
    op1Q  <= op1Next;
    op2Q  <= op2Next;
    destQ <= destTag_i; // dest tag rides along unchanged
  end

  assign opValid_o = validQ;
  assign op1_o     = op1Q;
  assign op2_o     = op2Q;
  assign opDest_o  = destQ;

endmodule

// File: source/readyTable.sv
//########################################
// physical register ready scoreboard
// reset or flush reloads the architectural pattern
// a wakeup or writeback beats an unmap of the same register
// requests of one cycle show on phyRegRdy_o the next
//########################################

`timescale 1ns/10ps

module readyTable #(
  parameter int WB_PORTS = 2
) (
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic                                flush_i,
  input  logic [WB_PORTS-1:0]                 unmapValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0] unmapTag_i,
  input  logic [WB_PORTS-1:0]                 wakeValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0] wakeTag_i,
  input  logic [WB_PORTS-1:0]                 wbValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0] wbTag_i,
  output regReadPkg::readyVec_t               phyRegRdy_o
);

  regReadPkg::readyVec_t rdyQ;
  regReadPkg::readyVec_t rdyNext;

  always_comb begin
    rdyNext = rdyQ;
    for (int p = 0; p < WB_PORTS; p++) begin
      if (unmapValid_i[p]) begin
        rdyNext[unmapTag_i[p]] = 1'b0;
      end
    end
    // sets come after all clears
    for (int p = 0; p < WB_PORTS; p++) begin
      if (wakeValid_i[p]) begin
        rdyNext[wakeTag_i[p]] = 1'b1;
      end
      if (wbValid_i[p]) begin
        rdyNext[wbTag_i[p]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      for (int i = 0; i < regReadPkg::PHYS_REGS; i++) begin
        rdyQ[i] <= (i < regReadPkg::ARCH_REGS); // arch regs start ready
      end
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule

// File: source/regRead.sv
//########################################
// register-read stage top
// issue in cycle N gives operands in cycle N+1
// no back-pressure, every valid is taken when high
// writeback ports feed the register file, the bypass
// and the ready table alike
//########################################

`timescale 1ns/10ps

module regRead #(
  parameter int LANES    = 2,
  parameter int WB_PORTS = 2
) (
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic [LANES-1:0]                    issueValid_i,
  input  regReadPkg::physTag_t [LANES-1:0]    src1Tag_i,
  input  regReadPkg::physTag_t [LANES-1:0]    src2Tag_i,
  input  regReadPkg::physTag_t [LANES-1:0]    destTag_i,
  input  regReadPkg::branchMask_t [LANES-1:0] branchMask_i,
  input  logic [WB_PORTS-1:0]                 wbValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0] wbTag_i,
  input  regReadPkg::regData_t [WB_PORTS-1:0] wbData_i,
  input  logic                                mispredictValid_i,
  input  regReadPkg::ckptId_t                 mispredictCkpt_i,
  input  logic [WB_PORTS-1:0]                 unmapValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0] unmapTag_i,
  input  logic [WB_PORTS-1:0]                 wakeValid_i,
  input  regReadPkg::physTag_t [WB_PORTS-1:0] wakeTag_i,
  input  logic                                flush_i,
  output logic [LANES-1:0]                    opValid_o,
  output regReadPkg::regData_t [LANES-1:0]    op1_o,
  output regReadPkg::regData_t [LANES-1:0]    op2_o,
  output regReadPkg::physTag_t [LANES-1:0]    opDest_o,
  output regReadPkg::readyVec_t               phyRegRdy_o
);

  regReadPkg::physTag_t [2*LANES-1:0] rfTag;
  regReadPkg::regData_t [2*LANES-1:0] rfData;

  // read ports in lane order, src1 then src2
  for (genvar l = 0; l < LANES; l++) begin : gRdTag
    assign rfTag[2*l]   = src1Tag_i[l];
    assign rfTag[2*l+1] = src2Tag_i[l];
  end

  physRegFile #(
    .LANES    (LANES),
    .WB_PORTS (WB_PORTS)
  ) regFile (
    .clk       (clk),
    .reset_i   (reset_i),
    .wbValid_i (wbValid_i),
    .wbTag_i   (wbTag_i),
    .wbData_i  (wbData_i),
    .rdTag_i   (rfTag),
    .rdData_o  (rfData)
  );

  operandForward #(
    .LANES    (LANES),
    .WB_PORTS (WB_PORTS)
  ) forward (
    .clk               (clk),
    .reset_i           (reset_i),
    .issueValid_i      (issueValid_i),
    .src1Tag_i         (src1Tag_i),
    .src2Tag_i         (src2Tag_i),
    .destTag_i         (destTag_i),
    .branchMask_i      (branchMask_i),
    .wbValid_i         (wbValid_i),
    .wbTag_i           (wbTag_i),
    .wbData_i          (wbData_i),
    .rfData_i          (rfData),
    .mispredictValid_i (mispredictValid_i),
    .mispredictCkpt_i  (mispredictCkpt_i),
    .opValid_o         (opValid_o),
    .op1_o             (op1_o),
    .op2_o             (op2_o),
    .opDest_o          (opDest_o)
  );

  readyTable #(
    .WB_PORTS (WB_PORTS)
  ) scoreboard (
    .clk          (clk),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .wakeValid_i  (wakeValid_i),
    .wakeTag_i    (wakeTag_i),
    .wbValid_i    (wbValid_i),
    .wbTag_i      (wbTag_i),
    .phyRegRdy_o  (phyRegRdy_o)
  );

endmodule

// File: bench/regRead_chk.sv
//########################################
// assertions bound to the register-read top
// assumes ARCH_REGS is below 32
//########################################

`timescale 1ns/10ps

module regReadChk #(
  parameter int LANES = 2
) (
  input logic                             clk,
  input logic                             reset_i,
  input logic                             flush_i,
  input logic [LANES-1:0]                 opValid_i,
  input regReadPkg::regData_t [LANES-1:0] op1_i,
  input regReadPkg::regData_t [LANES-1:0] op2_i,
  input regReadPkg::readyVec_t            phyRegRdy_i
);

  localparam regReadPkg::readyVec_t ARCH_READY =
    regReadPkg::readyVec_t'((64'd1 << regReadPkg::ARCH_REGS) - 64'd1);

  noValidAfterReset: assert property (@(posedge clk) reset_i |=> (opValid_i == '0))
    else $error("opValid_o high in the cycle after reset");

  // only lanes that are valid need defined operands
  for (genvar l = 0; l < LANES; l++) begin : gKnown
    knownOperands: assert property (@(posedge clk)
      opValid_i[l] |-> (!$isunknown(op1_i[l]) && !$isunknown(op2_i[l])))
      else $error("unknown operand bits while opValid_o is high");
  end

  archAfterFlush: assert property (@(posedge clk) flush_i |=> (phyRegRdy_i == ARCH_READY))
    else $error("phyRegRdy_o lost the architectural pattern after flush");

endmodule

bind regRead regReadChk #(.LANES(LANES)) chk (
  .clk         (clk),
  .reset_i     (reset_i),
  .flush_i     (flush_i),
  .opValid_i   (opValid_o),
  .op1_i       (op1_o),
  .op2_i       (op2_o),
  .phyRegRdy_i (phyRegRdy_o)
);

// File: bench/regReadTb.sv
//########################################
// testbench for the register-read stage
// runs with LANES = 2 and WB_PORTS = 2
// the model assumes reset clears the register file
// stops at the first mismatch
//########################################

`timescale 1ns/10ps

module regReadTb;

  localparam int LANES           = 2;
  localparam int WB_PORTS        = 2;
  localparam int PERIOD          = 10;
  localparam int RESET_CYCLES    = 10;
  localparam int DIRECTED_CYCLES = 30; // upper bound of the directed part
  localparam int RANDOM_CYCLES   = 400;
  localparam int TIMEOUT_NS      =
    (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * PERIOD + 20 * PERIOD;
  localparam logic [31:0] SEED   = 32'd13051;
  localparam regReadPkg::readyVec_t ARCH_READY =
    regReadPkg::readyVec_t'((64'd1 << regReadPkg::ARCH_REGS) - 64'd1);

  logic                                   clk;
  logic                                   reset_i;
  logic [LANES-1:0]                       issueValid;
  regReadPkg::physTag_t [LANES-1:0]       src1Tag;
  regReadPkg::physTag_t [LANES-1:0]       src2Tag;
  regReadPkg::physTag_t [LANES-1:0]       destTag;
  regReadPkg::branchMask_t [LANES-1:0]    branchMask;
  logic [WB_PORTS-1:0]                    wbValid;
  regReadPkg::physTag_t [WB_PORTS-1:0]    wbTag;
  regReadPkg::regData_t [WB_PORTS-1:0]    wbData;
  logic                                   mispredictValid;
  regReadPkg::ckptId_t                    mispredictCkpt;
  logic [WB_PORTS-1:0]                    unmapValid;
  regReadPkg::physTag_t [WB_PORTS-1:0]    unmapTag;
  logic [WB_PORTS-1:0]                    wakeValid;
  regReadPkg::physTag_t [WB_PORTS-1:0]    wakeTag;
  logic                                   flush;
  logic [LANES-1:0]                       opValid;
  regReadPkg::regData_t [LANES-1:0]       op1;
  regReadPkg::regData_t [LANES-1:0]       op2;
  regReadPkg::physTag_t [LANES-1:0]       opDest;
  regReadPkg::readyVec_t                  phyRegRdy;

  // reference state and the expectation for the cycle being driven
  regReadPkg::regData_t                   modelRegs [regReadPkg::PHYS_REGS];
  regReadPkg::readyVec_t                  modelRdy;
  logic                                   expArmed;
  logic [LANES-1:0]                       expValid;
  regReadPkg::regData_t [LANES-1:0]       expOp1;
  regReadPkg::regData_t [LANES-1:0]       expOp2;
  regReadPkg::physTag_t [LANES-1:0]       expDest;
  regReadPkg::readyVec_t                  expRdy;
  logic [31:0]                            rngState;

  regRead #(
    .LANES    (LANES),
    .WB_PORTS (WB_PORTS)
  ) dut (
    .clk               (clk),
    .reset_i           (reset_i),
    .issueValid_i      (issueValid),
    .src1Tag_i         (src1Tag),
    .src2Tag_i         (src2Tag),
    .destTag_i         (destTag),
    .branchMask_i      (branchMask),
    .wbValid_i         (wbValid),
    .wbTag_i           (wbTag),
    .wbData_i          (wbData),
    .mispredictValid_i (mispredictValid),
    .mispredictCkpt_i  (mispredictCkpt),
    .unmapValid_i      (unmapValid),
    .unmapTag_i        (unmapTag),
    .wakeValid_i       (wakeValid),
    .wakeTag_i         (wakeTag),
    .flush_i           (flush),
    .opValid_o         (opValid),
    .op1_o             (op1),
    .op2_o             (op2),
    .opDest_o          (opDest),
    .phyRegRdy_o       (phyRegRdy)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // lowest valid port with a matching tag wins over the stored value
  function automatic regReadPkg::regData_t expectOperand(input regReadPkg::physTag_t tag);
    regReadPkg::regData_t value;
    value = modelRegs[tag];
    for (int p = 0; p < WB_PORTS; p++) begin
      if (wbValid[p] && (wbTag[p] == tag)) begin
        value = wbData[p];
        break;
      end
    end
    return value;
  endfunction

  function automatic logic expectValid(input int lane);
    regReadPkg::branchMask_t killMask;
    killMask = mispredictValid ? (regReadPkg::branchMask_t'(1) << mispredictCkpt) : '0;
    return issueValid[lane] && ((branchMask[lane] & killMask) == '0);
  endfunction

  function automatic regReadPkg::readyVec_t expectReady();
    regReadPkg::readyVec_t clears;
    regReadPkg::readyVec_t sets;
    clears = '0;
    sets   = '0;
    for (int p = 0; p < WB_PORTS; p++) begin
      if (unmapValid[p]) clears[unmapTag[p]] = 1'b1;
      if (wakeValid[p])  sets[wakeTag[p]]    = 1'b1;
      if (wbValid[p])    sets[wbTag[p]]      = 1'b1;
    end
    if (flush) begin
      return ARCH_READY;
    end
    return (modelRdy & ~clears) | sets;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic clearInputs();
    issueValid      = '0;
    src1Tag         = '0;
    src2Tag         = '0;
    destTag         = '0;
    branchMask      = '0;
    wbValid         = '0;
    wbTag           = '0;
    wbData          = '0;
    mispredictValid = 1'b0;
    mispredictCkpt  = '0;
    unmapValid      = '0;
    unmapTag        = '0;
    wakeValid       = '0;
    wakeTag         = '0;
    flush           = 1'b0;
  endtask

  task automatic updateModel();
    logic taken;
    modelRdy = expectReady();
    for (int p = 0; p < WB_PORTS; p++) begin
      taken = 1'b0;
      for (int q = 0; q < p; q++) begin
        if (wbValid[q] && (wbTag[q] == wbTag[p])) taken = 1'b1; // lower port owns it
      end
      if (wbValid[p] && !taken) modelRegs[wbTag[p]] = wbData[p];
    end
  endtask

  // record what cycle N+1 must show for the inputs already driven
  task automatic commitCycle();
    for (int l = 0; l < LANES; l++) begin
      expValid[l] = expectValid(l);
      expOp1[l]   = expectOperand(src1Tag[l]);
      expOp2[l]   = expectOperand(src2Tag[l]);
      expDest[l]  = destTag[l];
    end
    expRdy   = expectReady();
    expArmed = 1'b1;
    updateModel();
    @(posedge clk);
    #1;
    expArmed = 1'b0;
    clearInputs();
  endtask

  task automatic randomCycle();
    logic [31:0] r;
    for (int l = 0; l < LANES; l++) begin
      r             = nextRandom();
      src1Tag[l]    = regReadPkg::physTag_t'(r);
      src2Tag[l]    = regReadPkg::physTag_t'(r >> 5);
      destTag[l]    = regReadPkg::physTag_t'(r >> 10);
      branchMask[l] = regReadPkg::branchMask_t'(r >> 15);
    end
    for (int p = 0; p < WB_PORTS; p++) begin
      r             = nextRandom();
      wbValid[p]    = r[0];
      wbTag[p]      = r[1] ? src1Tag[p % LANES] : regReadPkg::physTag_t'(r >> 2); // bias to hits
      wbData[p]     = nextRandom();
      unmapValid[p] = r[8] & r[9];
      unmapTag[p]   = regReadPkg::physTag_t'(r >> 10);
      wakeValid[p]  = r[15] & r[16];
      wakeTag[p]    = r[17] ? unmapTag[p] : regReadPkg::physTag_t'(r >> 18);
    end
    r               = nextRandom();
    mispredictValid = (r[1:0] == 2'b00);
    mispredictCkpt  = regReadPkg::ckptId_t'(r >> 2);
    flush           = (r[9:5] == 5'd0);
    issueValid      = r[10 +: LANES];
    commitCycle();
  endtask

  // expectations are latched at the edge and outputs compared at the falling edge
  initial begin
    logic                             armed;
    logic [LANES-1:0]                 wantValid;
    regReadPkg::regData_t [LANES-1:0] wantOp1;
    regReadPkg::regData_t [LANES-1:0] wantOp2;
    regReadPkg::physTag_t [LANES-1:0] wantDest;
    regReadPkg::readyVec_t            wantRdy;
    forever begin
      @(posedge clk);
      armed     = expArmed;
      wantValid = expValid;
      wantOp1   = expOp1;
      wantOp2   = expOp2;
      wantDest  = expDest;
      wantRdy   = expRdy;
      @(negedge clk);
      if (armed) begin
        checkValue("phyRegRdy_o", 32'(phyRegRdy), 32'(wantRdy));
        for (int l = 0; l < LANES; l++) begin
          checkValue($sformatf("opValid_o[%0d]", l), 32'(opValid[l]), 32'(wantValid[l]));
          if (wantValid[l]) begin
            checkValue($sformatf("op1_o[%0d]", l), op1[l], wantOp1[l]);
            checkValue($sformatf("op2_o[%0d]", l), op2[l], wantOp2[l]);
            checkValue($sformatf("opDest_o[%0d]", l), 32'(opDest[l]), 32'(wantDest[l]));
          end
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired, the test did not finish in the expected time");
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

  initial begin
    rngState = SEED;
    expArmed = 1'b0;
    reset_i  = 1'b1;
    clearInputs();
    for (int i = 0; i < regReadPkg::PHYS_REGS; i++) modelRegs[i] = '0;
    modelRdy = ARCH_READY;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // zero operands and the architectural ready pattern right after reset
    issueValid = '1;
    src1Tag[0] = 5'd3;
    src2Tag[0] = 5'd20;
    src1Tag[1] = 5'd31;
    src2Tag[1] = 5'd7;
    destTag[0] = 5'd10;
    destTag[1] = 5'd11;
    commitCycle();

    // register file read a few cycles after the write
    wbValid   = '1;
    wbTag[0]  = 5'd5;
    wbData[0] = 32'h1234_5678;
    wbTag[1]  = 5'd9;
    wbData[1] = 32'hcafe_0009;
    commitCycle();
    commitCycle();
    issueValid = '1;
    src1Tag[0] = 5'd5;
    src2Tag[0] = 5'd5;
    src1Tag[1] = 5'd9;
    src2Tag[1] = 5'd9;
    commitCycle();

    // port 0 must win when both ports write tag 12, now and in storage
    wbValid    = '1;
    wbTag[0]   = 5'd12;
    wbData[0]  = 32'haaaa_0001;
    wbTag[1]   = 5'd12;
    wbData[1]  = 32'hbbbb_0002;
    issueValid = '1;
    src1Tag[0] = 5'd12;
    src2Tag[0] = 5'd5;
    src1Tag[1] = 5'd9;
    src2Tag[1] = 5'd12;
    commitCycle();
    issueValid = '1;
    src1Tag[0] = 5'd12;
    src2Tag[1] = 5'd12;
    commitCycle();

    // squash lane 0 only
    issueValid      = '1;
    branchMask[0]   = 4'b0100;
    branchMask[1]   = 4'b1011;
    destTag[0]      = 5'd17;
    destTag[1]      = 5'd22;
    mispredictValid = 1'b1;
    mispredictCkpt  = 2'd2;
    commitCycle();

    // ready table requests
    unmapValid[0] = 1'b1;
    unmapTag[0]   = 5'd3;
    commitCycle();
    unmapValid   = '1;
    unmapTag[0]  = 5'd20;
    unmapTag[1]  = 5'd4;
    wakeValid[1] = 1'b1;
    wakeTag[1]   = 5'd20; // set beats unmap
    commitCycle();
    wakeValid[0] = 1'b1;
    wakeTag[0]   = 5'd3;
    commitCycle();
    wbValid[1] = 1'b1;
    wbTag[1]   = 5'd4;
    wbData[1]  = 32'h0000_0444;
    commitCycle();
    unmapValid   = '1;
    unmapTag[0]  = 5'd0;
    unmapTag[1]  = 5'd25;
    wakeValid[0] = 1'b1;
    wakeTag[0]   = 5'd30;
    flush        = 1'b1;
    commitCycle();
    commitCycle();

    repeat (RANDOM_CYCLES) randomCycle();
    commitCycle();
    @(negedge clk);
    #1;
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: files.f
source/regReadPkg.sv
source/physRegFile.sv
source/operandForward.sv
source/readyTable.sv
source/regRead.sv
bench/regRead_chk.sv
bench/regReadTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the register-read testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f files.f --top-module regReadTb -Mdir "$BUILD_DIR" -o regReadSim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/regReadSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "=== PASS ===" "$LOG_FILE"; then
  exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
